/* Makefile */
# Verilator flow for the heap engine, run from the project root
TOP = heapTb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f list.f

# Build and run, the result is decided by the pass line in the output
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

clean:
	rm -rf obj_dir

/* hw/heapAllocator.sv */
/* Array allocator. Freed arrays are reused last-freed first, then never-used
   arrays in order. Freeing an array twice is not checked here; the caller
   only frees allocated arrays. */
`timescale 1ns/1ns
module heapAllocator (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           clearStrobe,
  input  logic                           allocStrobe,
  input  logic                           freeStrobe,
  input  logic [heapPkg::ARRAY_BITS-1:0] array,
  output logic                           isAllocated,
  output logic                           allocOk,
  output logic [heapPkg::ARRAY_BITS-1:0] allocResult
);
  import heapPkg::*;

  logic [ARRAYS-1:0]     allocated;              // One flag per array
  logic [ARRAY_BITS-1:0] freed [ARRAYS];         // Stack of freed array numbers
  logic [ARRAY_BITS:0]   freedTop;               // Entries on the stack
  logic [ARRAY_BITS:0]   fresh;                  // Next never-used array
  logic                  fromStack;

  assign fromStack   = freedTop != '0;
  assign isAllocated = allocated[array];
  assign allocOk     = fromStack || fresh < (ARRAY_BITS+1)'(ARRAYS);
  assign allocResult = fromStack ? freed[freedTop[ARRAY_BITS-1:0] - 1'b1]
                                 : fresh[ARRAY_BITS-1:0];

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      allocated <= '0;
      freedTop  <= '0;
      fresh     <= '0;
    end else if (clearStrobe) begin              // Whole heap back to empty
      allocated <= '0;
      freedTop  <= '0;
      fresh     <= '0;
    end else if (allocStrobe && allocOk) begin
      allocated[allocResult] <= 1'b1;
      if (fromStack) freedTop <= freedTop - 1'b1;
      else fresh <= fresh + 1'b1;
    end else if (freeStrobe) begin
      allocated[array] <= 1'b0;
      freedTop         <= freedTop + 1'b1;
    end
  end

  // Stack entries are only meaningful below freedTop
  always_ff @(posedge clock) begin
    if (freeStrobe && !clearStrobe && !allocStrobe)
      freed[freedTop[ARRAY_BITS-1:0]] <= array;
  end
endmodule

/* hw/heapController.sv */
/* Command sequencer: accepts one request, checks it, issues its side effect
   and holds the response until taken. Searches wait for the scan to finish;
   all other commands answer one cycle after acceptance. */
`timescale 1ns/1ns
module heapController (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             reqValid,
  output logic                             reqReady,
  input  heapPkg::heapRequest_t            request,
  output logic                             rspValid,
  input  logic                             rspReady,
  output heapPkg::heapResponse_t           response,
  output logic                             allocStrobe,
  output logic                             freeStrobe,
  output logic                             clearStrobe,
  output logic [heapPkg::ARRAY_BITS-1:0]   array,
  input  logic                             isAllocated,
  input  logic                             allocOk,
  input  logic [heapPkg::ARRAY_BITS-1:0]   allocResult,
  output logic                             sizeUpdate,
  output heapPkg::sizeKind_t               sizeKind,
  output logic [heapPkg::SIZE_BITS-1:0]    sizeValue,
  input  logic [heapPkg::SIZE_BITS-1:0]    currentSize,
  output logic [heapPkg::INDEX_BITS-1:0]   elementIndex,
  output logic                             storeStrobe,
  output heapPkg::rmwOp_t                  rmwKind,
  output logic [heapPkg::DATA_BITS-1:0]    storeData,
  input  logic [heapPkg::DATA_BITS-1:0]    elementOld,
  output logic                             searchStart,
  output heapPkg::searchMode_t             searchMode,
  input  logic                             searchDone,
  input  logic [heapPkg::SIZE_BITS-1:0]    searchResult
);
  import heapPkg::*;

  typedef enum logic [1:0] {stIdle, stExecute, stRespond} state_t;

  state_t               state;
  heapRequest_t         req;                 // Request held until the response goes
  logic                 searchBusy;          // Waiting for the scan to finish
  logic                 useNew;              // Answer with the updated element
  logic [DATA_BITS-1:0] rspData;
  heapError_t           rspError;
  heapError_t           cmdError;
  logic [DATA_BITS-1:0] dataNext;
  logic [SIZE_BITS-1:0] sizeLess;            // Index of the top element for pop
  logic                 isRmw;
  logic                 isSearch;
  logic                 newValue;
  logic                 go;                  // Legal command in its first execute cycle
  logic                 finish;

  assign isRmw    = req.op inside {opAdd, opAddAfter, opSubtract, opSubAfter, opOr, opXor, opAnd};
  assign newValue = req.op inside {opAdd, opSubtract, opOr, opXor, opAnd};
  assign isSearch = req.op inside {opIndex, opLess, opGreater};
  assign sizeLess = currentSize - SIZE_BITS'(1);

  // Legality checks -------------------------------------------------------
  always_comb begin
    cmdError = errNone;
    if (req.op == opAlloc) begin
      if (!allocOk) cmdError = errOutOfMemory;           // Stack and counter exhausted
    end else if (req.op != opClear) begin
      if (!isAllocated) cmdError = errNotAllocated;
      else if ((req.op == opRead || isRmw) && SIZE_BITS'(req.index) >= currentSize)
        cmdError = errOutOfBounds;
      else if (req.op == opPush && currentSize == SIZE_BITS'(ARRAY_LENGTH))
        cmdError = errArrayFull;
      else if (req.op == opPop && currentSize == '0) cmdError = errArrayEmpty;
    end
  end

  // Side effects ----------------------------------------------------------
  assign go          = state == stExecute && !searchBusy && cmdError == errNone;
  assign clearStrobe = go && req.op == opClear;
  assign allocStrobe = go && req.op == opAlloc;
  assign freeStrobe  = go && req.op == opFree;
  assign storeStrobe = go && (req.op inside {opWrite, opPush} || isRmw);
  assign searchStart = go && isSearch;
  assign sizeUpdate  = go && req.op inside {opClear, opAlloc, opWrite, opPush, opPop};
  assign sizeValue   = SIZE_BITS'(req.index) + SIZE_BITS'(1); // Write extends to index+1
  assign array       = req.op == opAlloc ? allocResult : req.array;
  assign storeData   = req.data;
  assign finish      = state == stExecute && (!isSearch || cmdError != errNone || searchDone);

  always_comb begin
    elementIndex = req.index;
    if (req.op == opPush) elementIndex = currentSize[INDEX_BITS-1:0]; // Slot past the top
    if (req.op == opPop) elementIndex = sizeLess[INDEX_BITS-1:0];
    case (req.op)
      opClear: sizeKind = sizeClearAll;
      opAlloc: sizeKind = sizeZero;
      opPush:  sizeKind = sizeIncrement;
      opPop:   sizeKind = sizeDecrement;
      default: sizeKind = sizeExtend;
    endcase
    case (req.op)
      opAdd, opAddAfter:      rmwKind = rmwAdd;
      opSubtract, opSubAfter: rmwKind = rmwSubtract;
      opOr:                   rmwKind = rmwOr;
      opXor:                  rmwKind = rmwXor;
      opAnd:                  rmwKind = rmwAnd;
      default:                rmwKind = rmwWrite;  // Write and push
    endcase
    case (req.op)
      opLess:    searchMode = modeCountLess;
      opGreater: searchMode = modeCountGreater;
      default:   searchMode = modeFindEqual;
    endcase
  end

  // Response data ---------------------------------------------------------
  always_comb begin
    case (req.op)
      opAlloc:                    dataNext = DATA_BITS'(allocResult);
      opFree:                     dataNext = DATA_BITS'(req.array);
      opWrite, opPush:            dataNext = req.data;
      opRead, opPop, opAddAfter,
      opSubAfter:                 dataNext = elementOld;      // Value before any update
      opSize:                     dataNext = DATA_BITS'(currentSize);
      opIndex, opLess, opGreater: dataNext = DATA_BITS'(searchResult);
      default:                    dataNext = '0;
    endcase
    if (cmdError != errNone) dataNext = '0;
  end

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      state      <= stIdle;
      searchBusy <= 1'b0;
    end else begin
      case (state)
        stIdle:    if (reqValid) state <= stExecute;
        stExecute: begin
          if (searchStart) searchBusy <= 1'b1;
          if (finish) begin
            state      <= stRespond;
            searchBusy <= 1'b0;
          end
        end
        stRespond: if (rspReady) state <= stIdle;
        default:   state <= stIdle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == stIdle && reqValid) req <= request;
    if (finish) begin
      rspData  <= dataNext;
      rspError <= cmdError;
      useNew   <= newValue && cmdError == errNone;
    end
  end

  assign reqReady = state == stIdle;
  assign rspValid = state == stRespond;
  // Updated element is read back from the store once written
  assign response = '{data: useNew ? elementOld : rspData, error: rspError};
endmodule

/* hw/heapElementStore.sv */
/* Element registers for every array, with one update port and two reads.
   Contents are undefined until written; arithmetic wraps at DATA_BITS. */
`timescale 1ns/1ns
module heapElementStore (
  input  logic                           clock,
  input  logic [heapPkg::ARRAY_BITS-1:0] array,
  input  logic [heapPkg::INDEX_BITS-1:0] elementIndex,
  input  logic                           storeStrobe,
  input  heapPkg::rmwOp_t                rmwKind,
  input  logic [heapPkg::DATA_BITS-1:0]  storeData,
  output logic [heapPkg::DATA_BITS-1:0]  elementOld,
  input  logic [heapPkg::INDEX_BITS-1:0] scanIndex,
  output logic [heapPkg::DATA_BITS-1:0]  scanData
);
  import heapPkg::*;

  logic [DATA_BITS-1:0] elements [ARRAYS][ARRAY_LENGTH];
  logic [DATA_BITS-1:0] updated;               // Value written on the strobe

  assign elementOld = elements[array][elementIndex];
  assign scanData   = elements[array][scanIndex];  // Search unit port

  // Update unit -----------------------------------------------------------
  always_comb begin
    case (rmwKind)
      rmwAdd:      updated = elementOld + storeData;
      rmwSubtract: updated = elementOld - storeData;
      rmwOr:       updated = elementOld | storeData;
      rmwXor:      updated = elementOld ^ storeData;
      rmwAnd:      updated = elementOld & storeData;
      default:     updated = storeData;          // Plain write or push
    endcase
  end

  always_ff @(posedge clock) begin
    if (storeStrobe) elements[array][elementIndex] <= updated;
  end
endmodule

/* hw/heapPkg.sv */
/* Sizes, command codes and channel structs shared by the heap blocks.
   Array count and length are powers of two; a size carries one extra bit
   so that a full array's size fits. */
package heapPkg;
  localparam int ARRAY_BITS   = 3;                   // Bits in an array number
  localparam int ARRAYS       = 2 ** ARRAY_BITS;     // Arrays in the heap
  localparam int INDEX_BITS   = 3;                   // Bits in an element index
  localparam int ARRAY_LENGTH = 2 ** INDEX_BITS;     // Elements per array
  localparam int SIZE_BITS    = INDEX_BITS + 1;      // Size up to ARRAY_LENGTH
  localparam int DATA_BITS    = 12;                  // Element width

  typedef enum logic [4:0] {
    opClear, opAlloc, opFree, opWrite, opRead, opSize, opPush, opPop,
    opAdd, opAddAfter, opSubtract, opSubAfter, opOr, opXor, opAnd,
    opIndex, opLess, opGreater
  } heapOp_t;

  typedef enum logic [2:0] {
    errNone, errNotAllocated, errOutOfBounds, errArrayFull, errArrayEmpty,
    errOutOfMemory
  } heapError_t;

  typedef enum logic [1:0] {
    modeFindEqual, modeCountLess, modeCountGreater
  } searchMode_t;

  // rmwWrite stores the operand unchanged
  typedef enum logic [2:0] {
    rmwAdd, rmwSubtract, rmwOr, rmwXor, rmwAnd, rmwWrite
  } rmwOp_t;

  typedef enum logic [2:0] {
    sizeZero, sizeIncrement, sizeDecrement, sizeExtend, sizeClearAll
  } sizeKind_t;

  typedef struct packed {
    heapOp_t                op;                      // Command
    logic [ARRAY_BITS-1:0]  array;                   // Target array
    logic [INDEX_BITS-1:0]  index;                   // Element index
    logic [DATA_BITS-1:0]   data;                    // Operand or search key
  } heapRequest_t;

  typedef struct packed {
    logic [DATA_BITS-1:0]   data;                    // Result value
    heapError_t             error;                   // Zero when the command worked
  } heapResponse_t;
endpackage

/* hw/heapSearchUnit.sv */
/* Sequential scan of one array, one element per cycle over all positions.
   Inputs must stay stable from start to done; done lasts one cycle and the
   result is valid with it. Comparisons are unsigned. */
`timescale 1ns/1ns
module heapSearchUnit (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           searchStart,
  input  logic [heapPkg::ARRAY_BITS-1:0] array,
  input  heapPkg::searchMode_t           searchMode,
  input  logic [heapPkg::DATA_BITS-1:0]  key,
  input  logic [heapPkg::SIZE_BITS-1:0]  currentSize,
  output logic [heapPkg::INDEX_BITS-1:0] scanIndex,
  input  logic [heapPkg::DATA_BITS-1:0]  scanData,
  output logic                           searchDone,
  output logic [heapPkg::SIZE_BITS-1:0]  searchResult
);
  import heapPkg::*;

  logic                 busy;
  logic [SIZE_BITS-1:0] count;                   // Running count or last position
  logic                 inRange;                 // Position below the size
  logic                 hit;

  assign inRange = SIZE_BITS'(scanIndex) < currentSize;

  always_comb begin
    case (searchMode)
      modeCountLess:    hit = scanData < key;
      modeCountGreater: hit = scanData > key;
      default:          hit = scanData == key;
    endcase
    searchResult = count;
    if (inRange && hit) begin
      if (searchMode == modeFindEqual) searchResult = SIZE_BITS'(scanIndex) + 1'b1;
      else searchResult = count + 1'b1;
    end
  end

  assign searchDone = busy && scanIndex == INDEX_BITS'(ARRAY_LENGTH - 1);

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      busy      <= 1'b0;
      scanIndex <= '0;
      count     <= '0;
    end else if (searchStart) begin
      busy      <= 1'b1;
      scanIndex <= '0;
      count     <= '0;
    end else if (busy) begin
      count     <= searchResult;                 // Fold in this position
      scanIndex <= scanIndex + 1'b1;
      if (searchDone) busy <= 1'b0;
    end
  end
endmodule

/* hw/heapSizeTable.sv */
/* Current size of every array. Extend only ever grows a size; increment
   and decrement rely on the caller's full and empty checks. */
`timescale 1ns/1ns
module heapSizeTable (
  input  logic                           clock,
  input  logic                           reset,
  input  logic [heapPkg::ARRAY_BITS-1:0] array,
  input  logic                           sizeUpdate,
  input  heapPkg::sizeKind_t             sizeKind,
  input  logic [heapPkg::SIZE_BITS-1:0]  sizeValue,
  output logic [heapPkg::SIZE_BITS-1:0]  currentSize
);
  import heapPkg::*;

  logic [SIZE_BITS-1:0] sizes [ARRAYS];          // One size per array

  assign currentSize = sizes[array];

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      for (int i = 0; i < ARRAYS; i++) sizes[i] <= '0;
    end else if (sizeUpdate) begin
      case (sizeKind)
        sizeZero:      sizes[array] <= '0;       // Fresh allocation
        sizeIncrement: sizes[array] <= sizes[array] + 1'b1;
        sizeDecrement: sizes[array] <= sizes[array] - 1'b1;
        sizeExtend:    if (sizeValue > sizes[array]) sizes[array] <= sizeValue;
        sizeClearAll:  for (int i = 0; i < ARRAYS; i++) sizes[i] <= '0;
        default:       sizes[array] <= sizes[array];
      endcase
    end
  end
endmodule

/* hw/heapTop.sv */
/* Heap of small fixed-length arrays behind one request and one response
   channel. One command is in flight at a time. */
`timescale 1ns/1ns
module heapTop (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   reqValid,
  output logic                   reqReady,
  input  heapPkg::heapRequest_t  request,
  output logic                   rspValid,
  input  logic                   rspReady,
  output heapPkg::heapResponse_t response
);
  import heapPkg::*;

  logic                  allocStrobe;
  logic                  freeStrobe;
  logic                  clearStrobe;
  logic [ARRAY_BITS-1:0] array;            // Array the current command works on
  logic                  isAllocated;
  logic                  allocOk;
  logic [ARRAY_BITS-1:0] allocResult;
  logic                  sizeUpdate;
  sizeKind_t             sizeKind;
  logic [SIZE_BITS-1:0]  sizeValue;
  logic [SIZE_BITS-1:0]  currentSize;
  logic [INDEX_BITS-1:0] elementIndex;
  logic                  storeStrobe;
  rmwOp_t                rmwKind;
  logic [DATA_BITS-1:0]  storeData;        // Operand, also the search key
  logic [DATA_BITS-1:0]  elementOld;
  logic [INDEX_BITS-1:0] scanIndex;
  logic [DATA_BITS-1:0]  scanData;
  logic                  searchStart;
  searchMode_t           searchMode;
  logic                  searchDone;
  logic [SIZE_BITS-1:0]  searchResult;

  heapController heapController_i (.*);

  heapAllocator heapAllocator_i (.*);

  heapSizeTable heapSizeTable_i (.*);

  heapElementStore heapElementStore_i (.*);

  heapSearchUnit heapSearchUnit_i (
    .clock        (clock),
    .reset        (reset),
    .searchStart  (searchStart),
    .array        (array),
    .searchMode   (searchMode),
    .key          (storeData),
    .currentSize  (currentSize),
    .scanIndex    (scanIndex),
    .scanData     (scanData),
    .searchDone   (searchDone),
    .searchResult (searchResult)
  );
endmodule

/* list.f */
hw/heapPkg.sv
hw/heapAllocator.sv
hw/heapSizeTable.sv
hw/heapElementStore.sv
hw/heapSearchUnit.sv
hw/heapController.sv
hw/heapTop.sv
tb/heapTb.sv

/* tb/heapInput.txt */
// Heap commands with expected responses, every field in hex
// op array index data expectedData expectedError
00 0 0 000 000 0   // clear
01 0 0 000 000 0   // alloc gives 0, 1, 2
01 0 0 000 001 0
01 0 0 000 002 0
02 1 0 000 001 0   // free 1
01 0 0 000 001 0   // freed array comes back first
01 0 0 000 003 0
01 0 0 000 004 0
01 0 0 000 005 0
01 0 0 000 006 0
01 0 0 000 007 0
01 0 0 000 000 5   // out of memory
03 0 2 abc abc 0   // write extends size to 3
05 0 0 000 003 0
04 0 2 000 abc 0
04 0 3 000 000 2   // read at size
02 7 0 000 007 0
04 7 0 000 000 1   // freed array
02 7 0 000 000 1
07 2 0 000 000 4   // pop on empty
06 2 0 00a 00a 0
06 2 0 014 014 0
06 2 0 01e 01e 0
05 2 0 000 003 0
03 3 7 777 777 0   // size 8, array full
06 3 0 001 000 3
05 3 0 000 008 0
07 3 0 000 777 0
05 3 0 000 007 0
03 4 0 ffe ffe 0
08 4 0 005 003 0   // add wraps
04 4 0 000 003 0
09 4 0 010 003 0   // addAfter gives old value
0a 4 0 020 ff3 0
0b 4 0 0f3 ff3 0
0c 4 0 00f f0f 0
0d 4 0 0ff ff0 0
0e 4 0 3c3 3c0 0
04 4 0 000 3c0 0
08 4 1 001 000 2
11 2 0 00f 002 0   // array 2 holds 10, 20, 30
10 2 0 00f 001 0
0f 2 0 014 002 0
0f 2 0 063 000 0
06 2 0 014 014 0
0f 2 0 014 004 0   // last match wins
00 0 0 000 000 0
05 0 0 000 000 1
01 0 0 000 000 0

/* tb/heapTb.sv */
/* Testbench for heapTop. Commands and expected responses come from
   tb/heapInput.txt, so it runs from the project root. Request gaps and
   response stalls are pseudo-random from a fixed seed. */
`timescale 1ns/1ns
module heapTb;
  import heapPkg::*;

  localparam int          RESET_CYCLES = 16;
  localparam logic [31:0] SEED         = 32'h1ace_4e9b;

  logic          clock;
  logic          reset;
  logic          reqValid;
  logic          reqReady;
  heapRequest_t  request;
  logic          rspValid;
  logic          rspReady;
  heapResponse_t response;

  heapRequest_t         commands [$];          // Stimulus from the data file
  logic [DATA_BITS-1:0] expectData [$];
  heapError_t           expectError [$];
  logic                 loaded;                // Set once the file is read
  logic [31:0]          gapState;              // LCG state for request gaps
  logic [31:0]          stallState;            // LCG state for rspReady

  heapTop heapTop_i (.*);

  always #10 clock = ~clock;                   // 20 ns period

  function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic stopWithFailure(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  // Stimulus file ------------------------------------------------------
  task automatic loadCommands();
    int          fd;
    string       line;
    logic [31:0] field [6];                    // op array index data expData expError
    fd = $fopen("tb/heapInput.txt", "r");
    if (fd == 0) stopWithFailure("Cannot open the stimulus file tb/heapInput.txt");
    while ($fgets(line, fd) != 0) begin
      if ($sscanf(line, "%h %h %h %h %h %h", field[0], field[1], field[2], field[3],
                  field[4], field[5]) == 6) begin  // Comment lines give no fields
        commands.push_back(heapRequest_t'{op: heapOp_t'(field[0][4:0]),
                                          array: field[1][ARRAY_BITS-1:0],
                                          index: field[2][INDEX_BITS-1:0],
                                          data: field[3][DATA_BITS-1:0]});
        expectData.push_back(field[4][DATA_BITS-1:0]);
        expectError.push_back(heapError_t'(field[5][2:0]));
      end
    end
    $fclose(fd);
    if (commands.size() == 0) stopWithFailure("The stimulus file holds no commands");
  endtask

  // Request and response sides -----------------------------------------
  task automatic driveRequests();
    foreach (commands[i]) begin
      gapState = lcgNext(gapState);
      repeat (gapState[31:30]) begin           // Idle cycles before the request
        @(posedge clock);
        #2;
      end
      reqValid = 1'b1;
      request  = commands[i];
      while (!reqReady) begin                  // Previous command still in flight
        @(posedge clock);
        #2;
      end
      @(posedge clock);                        // Transfer edge
      #2;
      reqValid = 1'b0;
      assert (!reqReady) else stopWithFailure("reqReady stayed high after a request was accepted");
    end
  endtask

  task automatic collectResponses();
    heapResponse_t held;                       // Last response seen
    logic          pending;                    // Seen but not yet taken
    int            taken;
    pending = 1'b0;
    taken   = 0;
    while (taken < commands.size()) begin
      @(posedge clock);
      #2;
      stallState = lcgNext(stallState);
      rspReady   = stallState[31];
      if (pending) begin
        assert (rspValid) else stopWithFailure("rspValid dropped before the response was taken");
        assert (response == held) else stopWithFailure($sformatf(
          "FAILED at %0t ns: response changed while stalled, expected %h, got %h",
          $time, held, response));
      end
      if (rspValid) begin
        assert (!reqReady) else stopWithFailure("reqReady was high while a response was waiting");
        assert (response.data == expectData[taken]) else stopWithFailure($sformatf(
          "FAILED at %0t ns: response.data of command %0d, expected %h, got %h",
          $time, taken, expectData[taken], response.data));
        assert (response.error == expectError[taken]) else stopWithFailure($sformatf(
          "FAILED at %0t ns: response.error of command %0d, expected %0d, got %0d",
          $time, taken, expectError[taken], response.error));
        held    = response;
        pending = !rspReady;
        if (rspReady) taken++;
      end
    end
    @(posedge clock);                          // Last response goes here
    #2;
    rspReady = 1'b0;
  endtask

  initial begin
    clock      = 1'b0;
    reset      = 1'b0;
    reqValid   = 1'b0;
    request    = '0;
    rspReady   = 1'b0;
    loaded     = 1'b0;
    gapState   = SEED;
    stallState = ~SEED;                        // Separate stream for stalls
    loadCommands();
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    #2;
    reset = 1'b1;
    fork
      driveRequests();
      collectResponses();
    join
    $display("All %0d commands answered in order", commands.size());
    $display("Simulation completed successfully");
    $finish;
  end

  // Budget covers the slowest command plus gaps and stalls
  initial begin
    wait (loaded);
    repeat (RESET_CYCLES + commands.size() * (ARRAY_LENGTH + 12)) @(posedge clock);
    stopWithFailure("Watchdog expired, no response arrived in time");
  end
endmodule
